//--- axi_row_reader.sv
`timescale 1ns/1ps
`default_nettype none

module axi_row_reader
	import layer_fetch_pkg::*;
(
	input  wire                                  clk,
	input  wire                                  reset_n,
	input  wire cfg_t                            cfg,
	input  wire fetch_req_t                      fetch_req,
	input  wire                                  fetch_valid,
	input  wire                                  ar_ready,
	input  wire [axi_data_w-1:0]                 r_data,
	input  wire                                  r_last,
	input  wire                                  r_valid,
	output logic                                 fetch_done,
	output logic [axi_addr_w-1:0]                ar_addr,
	output logic [7:0]                           ar_len,
	output logic                                 ar_valid,
	output logic                                 r_ready,
	output logic                                 wr_en,
	output line_sel_e                            wr_line,
	output logic [$clog2(words_per_line)-1:0]    wr_word,
	output logic [axi_data_w-1:0]                wr_data
);

	logic                              burst_open;
	logic [$clog2(words_per_line)-1:0] beat_cnt;
	logic                              beat;
	logic                              take;

	assign beat = r_valid && r_ready;
	// no new request while the previous one is still finishing
	assign take = fetch_valid && !ar_valid && !burst_open && !fetch_done;

	assign r_ready = burst_open;
	assign wr_en   = beat;
	assign wr_word = beat_cnt;
	assign wr_data = r_data;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			ar_valid   <= 1'b0;
			burst_open <= 1'b0;
			fetch_done <= 1'b0;
			beat_cnt   <= '0;
		end else begin
			fetch_done <= beat && r_last;
			if (take) begin
				ar_valid <= 1'b1;
				beat_cnt <= '0;
			end else if (ar_valid && ar_ready) begin
				ar_valid   <= 1'b0;
				burst_open <= 1'b1;
			end
			if (beat) begin
				beat_cnt <= beat_cnt + 1'b1;
				if (r_last)
					burst_open <= 1'b0;
			end
		end
	end

	// layer block + row offset
	always_ff @(posedge clk) begin
		if (take) begin
			ar_addr <= cfg.base_addr + (axi_addr_w'(fetch_req.layer) << layer_shift)
				+ axi_addr_w'(fetch_req.src_row) * axi_addr_w'(cfg.row_stride);
			ar_len  <= 8'(cfg.cols[dim_w-1:2]) - 8'd1;
			wr_line <= fetch_req.line;
		end
	end

	a_ar_stable: assert property (@(posedge clk) disable iff (!reset_n)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr) && $stable(ar_len));

	a_last_beat: assert property (@(posedge clk) disable iff (!reset_n)
		r_valid |-> burst_open && (!r_ready || r_last == (beat_cnt == ar_len[3:0])));

endmodule

`default_nettype wire

//--- input_layer_reader.sv
`timescale 1ns/1ps
`default_nettype none

module input_layer_reader
	import layer_fetch_pkg::*;
(
	input  wire                   clk,
	input  wire                   reset_n,
	input  wire                   start,
	input  wire cfg_t             cfg,
	output win_beat_t             win,
	output logic                  win_valid,
	input  wire                   win_ready,
	output logic                  read_done,
	output logic [axi_addr_w-1:0] ar_addr,
	output logic [7:0]            ar_len,
	output logic                  ar_valid,
	input  wire                   ar_ready,
	input  wire [axi_data_w-1:0]  r_data,
	input  wire                   r_last,
	input  wire                   r_valid,
	output logic                  r_ready
);

	fetch_req_t                        fetch_req;
	logic                              fetch_valid;
	logic                              fetch_done;
	logic [2:0]                        pad_lines;
	logic                              stream_go;
	logic                              row_end;
	logic                              group_advance;
	logic [dim_w-1:0]                  layer;
	logic [dim_w-1:0]                  row;
	logic                              last_layer;
	logic                              last_row;
	logic                              wr_en;
	line_sel_e                         wr_line;
	logic [$clog2(words_per_line)-1:0] wr_word;
	logic [axi_data_w-1:0]             wr_data;
	logic [$clog2(words_per_line)-1:0] rd_word;
	logic [$clog2(pix_per_beat)-1:0]   rd_pix;
	logic [0:2][pix_w-1:0]             rd_col;

	// ------------------------------
	// control
	// ------------------------------
	window_seq_fsm u_fsm (
		.clk(clk), .reset_n(reset_n), .start(start), .cfg(cfg),
		.layer(layer), .row(row), .last_layer(last_layer), .last_row(last_row),
		.fetch_done(fetch_done), .row_end(row_end), .fetch_req(fetch_req),
		.fetch_valid(fetch_valid), .pad_lines(pad_lines), .stream_go(stream_go),
		.group_advance(group_advance), .read_done(read_done)
	);

	stream_position_counter u_pos (
		.clk(clk), .reset_n(reset_n), .start(start), .cfg(cfg),
		.group_advance(group_advance), .layer(layer), .row(row),
		.last_layer(last_layer), .last_row(last_row)
	);

	// ------------------------------
	// datapath
	// ------------------------------
	axi_row_reader u_reader (
		.clk(clk), .reset_n(reset_n), .cfg(cfg), .fetch_req(fetch_req),
		.fetch_valid(fetch_valid), .ar_ready(ar_ready), .r_data(r_data),
		.r_last(r_last), .r_valid(r_valid), .fetch_done(fetch_done),
		.ar_addr(ar_addr), .ar_len(ar_len), .ar_valid(ar_valid), .r_ready(r_ready),
		.wr_en(wr_en), .wr_line(wr_line), .wr_word(wr_word), .wr_data(wr_data)
	);

	line_buffers u_lines (
		.clk(clk), .wr_en(wr_en), .wr_line(wr_line), .wr_word(wr_word),
		.wr_data(wr_data), .pad_lines(pad_lines), .rd_word(rd_word),
		.rd_pix(rd_pix), .rd_col(rd_col)
	);

	window_shifter u_shifter (
		.clk(clk), .reset_n(reset_n), .cfg(cfg), .stream_go(stream_go),
		.layer(layer), .row(row), .rd_col(rd_col), .win_ready(win_ready),
		.rd_word(rd_word), .rd_pix(rd_pix), .win(win), .win_valid(win_valid),
		.row_end(row_end)
	);

endmodule

`default_nettype wire

//--- layer_fetch_pkg.sv
`default_nettype none

package layer_fetch_pkg;

	// ------------------------------
	// sizes
	// ------------------------------
	localparam int pix_w          = 16;
	localparam int axi_data_w     = 64;
	localparam int pix_per_beat   = 4;
	localparam int axi_addr_w     = 32;
	localparam int max_cols       = 64;
	localparam int words_per_line = 16;
	// each layer sits in its own 8 KB block
	localparam int layer_shift    = 13;
	localparam int dim_w          = 7;

	// ------------------------------
	// types
	// ------------------------------
	typedef enum logic [2:0] {
		IDLE,
		FETCH,
		STREAM,
		NEXT,
		DONE
	} seq_state_e;

	// line slot order matches the pad_lines bit order
	typedef enum logic [1:0] {
		LINE_TOP,
		LINE_MID,
		LINE_BOT
	} line_sel_e;

	typedef struct packed {
		logic [axi_addr_w-1:0] base_addr;
		logic [15:0]           row_stride;
		logic [dim_w-1:0]      layers;
		logic [dim_w-1:0]      rows;
		logic [dim_w-1:0]      cols;
	} cfg_t;

	typedef struct packed {
		logic [dim_w-1:0] layer;
		logic [dim_w-1:0] src_row;
		line_sel_e        line;
	} fetch_req_t;

	// index 0 of each row is the left column
	typedef struct packed {
		logic [0:2][pix_w-1:0] top;
		logic [0:2][pix_w-1:0] mid;
		logic [0:2][pix_w-1:0] bot;
	} window_t;

	typedef struct packed {
		window_t          window;
		logic [dim_w-1:0] layer;
		logic [dim_w-1:0] row;
		logic [dim_w-1:0] col;
	} win_beat_t;

endpackage

`default_nettype wire

//--- line_buffers.sv
`timescale 1ns/1ps
`default_nettype none

module line_buffers
	import layer_fetch_pkg::*;
(
	input  wire                                  clk,
	input  wire                                  wr_en,
	input  wire line_sel_e                       wr_line,
	input  wire [$clog2(words_per_line)-1:0]     wr_word,
	input  wire [axi_data_w-1:0]                 wr_data,
	input  wire [2:0]                            pad_lines,
	input  wire [$clog2(words_per_line)-1:0]     rd_word,
	input  wire [$clog2(pix_per_beat)-1:0]       rd_pix,
	output logic [0:2][pix_w-1:0]                rd_col
);

	logic [$clog2(pix_per_beat)-1:0] pix_q;

	always_ff @(posedge clk) begin
		pix_q <= rd_pix;
	end

	// ------------------------------
	// one memory per line slot
	// ------------------------------
	for (genvar l = 0; l < 3; l++) begin : g_line
		logic [axi_data_w-1:0] mem [words_per_line];
		logic [axi_data_w-1:0] word_q;

		always_ff @(posedge clk) begin
			if (wr_en && wr_line == line_sel_e'(l))
				mem[wr_word] <= wr_data;
			word_q <= mem[rd_word];
		end

		// pixel 0 of a beat is the low half-word
		assign rd_col[l] = pad_lines[l] ? '0 : word_q[pix_q*pix_w +: pix_w];
	end

endmodule

`default_nettype wire

//--- stream_position_counter.sv
`timescale 1ns/1ps
`default_nettype none

module stream_position_counter
	import layer_fetch_pkg::*;
(
	input  wire              clk,
	input  wire              reset_n,
	input  wire              start,
	input  wire cfg_t        cfg,
	input  wire              group_advance,
	output logic [dim_w-1:0] layer,
	output logic [dim_w-1:0] row,
	output logic             last_layer,
	output logic             last_row
);

	logic             running;
	logic [dim_w-1:0] layers_q;
	logic [dim_w-1:0] rows_q;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			running    <= 1'b0;
			layer      <= '0;
			row        <= '0;
			last_layer <= 1'b0;
			last_row   <= 1'b0;
		end else if (start && !running) begin
			running    <= 1'b1;
			layer      <= '0;
			row        <= '0;
			last_layer <= (cfg.layers == 7'd1);
			last_row   <= (cfg.rows == 7'd1);
		end else if (group_advance) begin
			// layer wraps first, then carries into row
			if (last_layer) begin
				layer      <= '0;
				last_layer <= (layers_q == 7'd1);
				if (last_row) begin
					row      <= '0;
					running  <= 1'b0;
					last_row <= (rows_q == 7'd1);
				end else begin
					row      <= row + 1'b1;
					last_row <= (row + 7'd2 == rows_q);
				end
			end else begin
				layer      <= layer + 1'b1;
				last_layer <= (layer + 7'd2 == layers_q);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start && !running) begin
			layers_q <= cfg.layers;
			rows_q   <= cfg.rows;
		end
	end

endmodule

`default_nettype wire

//--- tb.f
layer_fetch_pkg.sv
window_seq_fsm.sv
stream_position_counter.sv
axi_row_reader.sv
line_buffers.sv
window_shifter.sv
input_layer_reader.sv
tb_axi_mem.sv
tb_input_layer_reader.sv

//--- tb_axi_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem
	import layer_fetch_pkg::*;
(
	input  wire                   clk,
	input  wire [axi_addr_w-1:0]  ar_addr,
	input  wire [7:0]             ar_len,
	input  wire                   ar_valid,
	output logic                  ar_ready,
	output logic [axi_data_w-1:0] r_data,
	output logic                  r_last,
	output logic                  r_valid,
	input  wire                   r_ready
);

	// byte address bits 14:3 pick the word so the image repeats every 32 KB
	logic [axi_data_w-1:0] mem [4096];

	task automatic fill_random();
		for (int i = 0; i < 4096; i++)
			mem[i] = {$urandom, $urandom};
	endtask

	// inputs of the DUT change 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	// ------------------------------
	// read slave for one burst at a time
	// ------------------------------
	initial begin
		logic [axi_addr_w-1:0] addr;
		logic [7:0]            len;
		logic [11:0]           word;
		logic                  ready_seen;
		ar_ready = 1'b0;
		r_valid  = 1'b0;
		r_last   = 1'b0;
		r_data   = '0;
		forever begin
			next_cycle();
			if (ar_valid === 1'b1) begin
				addr = ar_addr;
				len  = ar_len;
				repeat ($urandom_range(0, 3)) next_cycle();
				ar_ready = 1'b1;
				next_cycle();
				ar_ready = 1'b0;
				for (int beat = 0; beat <= len; beat++) begin
					// gap before roughly one beat in three
					if ($urandom_range(0, 2) == 0)
						repeat ($urandom_range(1, 2)) next_cycle();
					word    = addr[14:3] + 12'(beat);
					r_valid = 1'b1;
					r_data  = mem[word];
					r_last  = (beat == len);
					do begin
						ready_seen = (r_ready === 1'b1);
						next_cycle();
					end while (!ready_seen);
					r_valid = 1'b0;
					r_last  = 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- tb_input_layer_reader.sv
`timescale 1ns/1ps
`default_nettype none

module tb_input_layer_reader
	import layer_fetch_pkg::*;
();

	logic                  clk;
	logic                  reset_n;
	logic                  start;
	cfg_t                  cfg;
	win_beat_t             win;
	logic                  win_valid;
	logic                  win_ready;
	logic                  read_done;
	logic [axi_addr_w-1:0] ar_addr;
	logic [7:0]            ar_len;
	logic                  ar_valid;
	logic                  ar_ready;
	logic [axi_data_w-1:0] r_data;
	logic                  r_last;
	logic                  r_valid;
	logic                  r_ready;

	// one entry per test
	string       t_name   [5] = '{"single layer edges", "layer order", "random stalls",
		"ar traffic", "single row rerun"};
	int          t_layers [5] = '{1, 3, 2, 2, 2};
	int          t_rows   [5] = '{3, 4, 3, 5, 1};
	int          t_cols   [5] = '{8, 16, 12, 64, 4};
	int          t_stride [5] = '{16, 64, 24, 128, 8};
	int          t_stall  [5] = '{0, 0, 40, 10, 20};
	logic [31:0] t_base   [5] = '{32'h0004_0000, 32'h1000_2000, 32'h0000_0108,
		32'h2000_0040, 32'h0300_0010};

	win_beat_t             exp_win [$];
	logic [axi_addr_w-1:0] exp_ar [$];
	win_beat_t             held_win;
	logic                  hold_pending;
	logic                  done_due;
	logic                  done_seen;
	logic                  monitor_on;
	logic                  burst_out;
	int                    cur_rows;
	int                    cur_cols;
	int                    stall_pct;
	int                    errors;
	int                    win_count;
	int                    windows_total;
	int                    cycle_count = 0;
	int                    cycle_limit;

	input_layer_reader dut0 (
		.clk(clk), .reset_n(reset_n), .start(start), .cfg(cfg), .win(win),
		.win_valid(win_valid), .win_ready(win_ready), .read_done(read_done),
		.ar_addr(ar_addr), .ar_len(ar_len), .ar_valid(ar_valid), .ar_ready(ar_ready),
		.r_data(r_data), .r_last(r_last), .r_valid(r_valid), .r_ready(r_ready)
	);

	tb_axi_mem mem0 (
		.clk(clk), .ar_addr(ar_addr), .ar_len(ar_len), .ar_valid(ar_valid),
		.ar_ready(ar_ready), .r_data(r_data), .r_last(r_last), .r_valid(r_valid),
		.r_ready(r_ready)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	always @(posedge clk) begin
		#1;
		win_ready = ($urandom_range(0, 99) >= stall_pct);
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Done: errors found");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [$bits(win_beat_t)-1:0] expected,
		input logic [$bits(win_beat_t)-1:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	// ------------------------------
	// reference model
	// ------------------------------
	// zero outside the image, else the pixel at the address rule
	function automatic logic [pix_w-1:0] model_pix(input int t, input int l, input int r,
		input int c);
		logic [axi_addr_w-1:0] addr;
		logic [axi_data_w-1:0] word;
		if (r < 0 || r >= t_rows[t] || c < 0 || c >= t_cols[t])
			return '0;
		addr = t_base[t] + (l << layer_shift) + r * t_stride[t] + c * 2;
		word = mem0.mem[addr[14:3]];
		return word[addr[2:1]*pix_w +: pix_w];
	endfunction

	task automatic build_expected(input int t);
		win_beat_t w;
		exp_win.delete();
		exp_ar.delete();
		for (int r = 0; r < t_rows[t]; r++) begin
			for (int l = 0; l < t_layers[t]; l++) begin
				// source rows above, at and below, in that order
				for (int s = r - 1; s <= r + 1; s++) begin
					if (s >= 0 && s < t_rows[t])
						exp_ar.push_back(t_base[t] + (l << layer_shift) + s * t_stride[t]);
				end
				for (int c = 0; c < t_cols[t]; c++) begin
					for (int k = 0; k < 3; k++) begin
						w.window.top[k] = model_pix(t, l, r - 1, c - 1 + k);
						w.window.mid[k] = model_pix(t, l, r, c - 1 + k);
						w.window.bot[k] = model_pix(t, l, r + 1, c - 1 + k);
					end
					w.layer = dim_w'(l);
					w.row   = dim_w'(r);
					w.col   = dim_w'(c);
					exp_win.push_back(w);
				end
			end
		end
	endtask

	// ------------------------------
	// monitors sampled mid cycle
	// ------------------------------
	always @(negedge clk) begin
		if (monitor_on) begin
			// a stalled window must come back unchanged
			if (hold_pending) begin
				check_value("win_valid", 1, win_valid);
				check_value("win", held_win, win);
			end
			hold_pending = (win_valid === 1'b1) && (win_ready === 1'b0);
			held_win     = win;
			check_value("read_done", done_due, read_done);
			if (read_done === 1'b1)
				done_seen = 1'b1;
			done_due = 1'b0;
			if (win_valid === 1'b1 && win_ready === 1'b1) begin
				if (exp_win.size() == 0) begin
					errors++;
					$display("a window was transferred at %0t when none was expected", $time);
				end else begin
					check_value("win", exp_win.pop_front(), win);
					if (cur_rows == 1) begin
						check_value("win.window.top", 0, win.window.top);
						check_value("win.window.bot", 0, win.window.bot);
					end
					win_count++;
					done_due = (exp_win.size() == 0);
				end
			end
			// r_ready only while a burst is outstanding
			if (!burst_out)
				check_value("r_ready", 0, r_ready);
			if (r_valid === 1'b1 && r_ready === 1'b1 && r_last === 1'b1)
				burst_out = 1'b0;
			if (ar_valid === 1'b1 && ar_ready === 1'b1) begin
				burst_out = 1'b1;
				if (exp_ar.size() == 0) begin
					errors++;
					$display("a read burst was requested at %0t when none was expected", $time);
				end else begin
					check_value("ar_addr", exp_ar.pop_front(), ar_addr);
					check_value("ar_len", cur_cols / 4 - 1, ar_len);
				end
			end
		end
	end

	task automatic run_test(input int t);
		int errors_before;
		errors_before = errors;
		win_count     = 0;
		done_seen     = 1'b0;
		build_expected(t);
		cur_rows  = t_rows[t];
		cur_cols  = t_cols[t];
		stall_pct = t_stall[t];
		@(posedge clk);
		#1;
		cfg.base_addr  = t_base[t];
		cfg.row_stride = 16'(t_stride[t]);
		cfg.layers     = dim_w'(t_layers[t]);
		cfg.rows       = dim_w'(t_rows[t]);
		cfg.cols       = dim_w'(t_cols[t]);
		start          = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		wait (done_seen);
		repeat (2) @(posedge clk);
		if (exp_win.size() != 0 || exp_ar.size() != 0) begin
			errors++;
			$display("%0d windows and %0d read bursts never arrived", exp_win.size(),
				exp_ar.size());
		end
		windows_total += win_count;
		$display("test %0d %s: %0d windows, %0d errors", t + 1, t_name[t], win_count,
			errors - errors_before);
	endtask

	initial begin
		void'($urandom(32'h0ebe_26bd));
		reset_n       = 1'b0;
		start         = 1'b0;
		cfg           = '0;
		win_ready     = 1'b1;
		stall_pct     = 0;
		errors        = 0;
		windows_total = 0;
		monitor_on    = 1'b0;
		hold_pending  = 1'b0;
		done_due      = 1'b0;
		done_seen     = 1'b0;
		burst_out     = 1'b0;
		cycle_limit   = 0;
		for (int t = 0; t < $size(t_rows); t++)
			cycle_limit += 200 * t_layers[t] * t_rows[t] * t_cols[t];
		mem0.fill_random();
		repeat (3) @(posedge clk);
		#1;
		reset_n    = 1'b1;
		monitor_on = 1'b1;
		for (int t = 0; t < $size(t_rows); t++)
			run_test(t);
		$display("%0d tests, %0d windows, %0d errors", $size(t_rows), windows_total, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- window_seq_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module window_seq_fsm
	import layer_fetch_pkg::*;
(
	input  wire              clk,
	input  wire              reset_n,
	input  wire              start,
	input  wire cfg_t        cfg,
	input  wire [dim_w-1:0]  layer,
	input  wire [dim_w-1:0]  row,
	input  wire              last_layer,
	input  wire              last_row,
	input  wire              fetch_done,
	input  wire              row_end,
	output fetch_req_t       fetch_req,
	output logic             fetch_valid,
	output logic [2:0]       pad_lines,
	output logic             stream_go,
	output logic             group_advance,
	output logic             read_done
);

	seq_state_e       state;
	line_sel_e        slot;
	logic [dim_w-1:0] rows_q;
	// source row plus one, so row -1 shows up as zero
	logic [dim_w:0]   src_p1;
	logic             outside;
	logic             slot_done;

	assign src_p1    = {1'b0, row} + (dim_w + 1)'(slot);
	assign outside   = (src_p1 == '0) || (src_p1 > {1'b0, rows_q});
	assign slot_done = (state == FETCH) && (outside || fetch_done);

	assign fetch_valid   = (state == FETCH) && !outside;
	assign fetch_req     = '{layer: layer, src_row: dim_w'(src_p1 - 1'b1), line: slot};
	assign group_advance = (state == STREAM) && row_end;
	assign read_done     = group_advance && last_layer && last_row;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state     <= IDLE;
			slot      <= LINE_TOP;
			pad_lines <= '0;
			stream_go <= 1'b0;
		end else begin
			stream_go <= 1'b0;
			case (state)
				IDLE, DONE: begin
					// first group is row 0 so its top slot is padding
					if (start) begin
						state     <= FETCH;
						slot      <= LINE_MID;
						pad_lines <= 3'b001;
					end
				end
				FETCH: begin
					if (slot_done) begin
						if (outside)
							pad_lines[slot] <= 1'b1;
						if (slot == LINE_BOT) begin
							state     <= STREAM;
							stream_go <= 1'b1;
						end else begin
							slot <= line_sel_e'(slot + 2'd1);
						end
					end
				end
				STREAM: begin
					if (row_end)
						state <= (last_layer && last_row) ? DONE : NEXT;
				end
				NEXT: begin
					state     <= FETCH;
					slot      <= LINE_TOP;
					pad_lines <= '0;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if ((state == IDLE || state == DONE) && start)
			rows_q <= cfg.rows;
	end

	// fetch_done only answers a request that is still open
	a_done_in_fetch: assert property (@(posedge clk) disable iff (!reset_n)
		fetch_done |-> fetch_valid);

endmodule

`default_nettype wire

//--- window_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module window_shifter
	import layer_fetch_pkg::*;
(
	input  wire                                  clk,
	input  wire                                  reset_n,
	input  wire cfg_t                            cfg,
	input  wire                                  stream_go,
	input  wire [dim_w-1:0]                      layer,
	input  wire [dim_w-1:0]                      row,
	input  wire [0:2][pix_w-1:0]                 rd_col,
	input  wire                                  win_ready,
	output logic [$clog2(words_per_line)-1:0]    rd_word,
	output logic [$clog2(pix_per_beat)-1:0]      rd_pix,
	output win_beat_t                            win,
	output logic                                 win_valid,
	output logic                                 row_end
);

	logic                  active;
	logic                  primed;
	logic [dim_w-1:0]      in_idx;
	logic [dim_w-1:0]      out_col;
	logic [dim_w-1:0]      rd_addr;
	logic [0:2][pix_w-1:0] col_l;
	logic [0:2][pix_w-1:0] col_c;
	logic [0:2][pix_w-1:0] col_r;
	logic                  shift;
	logic                  accept;

	assign accept = win_valid && win_ready;
	// in_idx == cols feeds the zero column past the right edge
	assign shift  = active && (in_idx <= cfg.cols) && (!win_valid || win_ready);

	// address of the column that rd_col shows next cycle
	assign rd_addr = stream_go ? '0 : in_idx + dim_w'(shift);
	assign rd_word = rd_addr[$clog2(max_cols)-1:$clog2(pix_per_beat)];
	assign rd_pix  = rd_addr[$clog2(pix_per_beat)-1:0];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			active    <= 1'b0;
			primed    <= 1'b0;
			win_valid <= 1'b0;
			row_end   <= 1'b0;
			in_idx    <= '0;
			out_col   <= '0;
		end else begin
			row_end <= accept && (out_col == cfg.cols - 1'b1);
			if (stream_go) begin
				active    <= 1'b1;
				primed    <= 1'b0;
				win_valid <= 1'b0;
				in_idx    <= '0;
				out_col   <= '0;
			end else begin
				if (accept)
					out_col <= out_col + 1'b1;
				if (accept && out_col == cfg.cols - 1'b1)
					active <= 1'b0;
				// second column shifted in gives the first full window
				if (shift) begin
					in_idx    <= in_idx + 1'b1;
					primed    <= 1'b1;
					win_valid <= primed;
				end else if (accept) begin
					win_valid <= 1'b0;
				end
			end
		end
	end

	// cleared on go for the left edge zero column
	always_ff @(posedge clk) begin
		if (stream_go) begin
			col_l <= '0;
			col_c <= '0;
			col_r <= '0;
		end else if (shift) begin
			col_l <= col_c;
			col_c <= col_r;
			col_r <= (in_idx == cfg.cols) ? '0 : rd_col;
		end
	end

	always_comb begin
		win.window.top = {col_l[0], col_c[0], col_r[0]};
		win.window.mid = {col_l[1], col_c[1], col_r[1]};
		win.window.bot = {col_l[2], col_c[2], col_r[2]};
		win.layer      = layer;
		win.row        = row;
		win.col        = out_col;
	end

	a_win_hold: assert property (@(posedge clk) disable iff (!reset_n)
		win_valid && !win_ready |=> win_valid && $stable(win));

endmodule

`default_nettype wire
